// File: sim.f
+incdir+src
+incdir+bench
src/ntt_pkg.sv
src/ntt_mod_mult.sv
src/ntt_butterfly.sv
src/ntt_butterfly_2x2.sv
bench/tb_ntt_butterfly_2x2.sv

// File: bench/ntt_ref.svh
// Reference model: modular arithmetic, butterfly and full 2x2 network results
`ifndef NTT_REF_SVH
`define NTT_REF_SVH

// --------------------------------------------------
// Plain modular arithmetic on wide integers
// --------------------------------------------------

function automatic logic [`NTT_REG_SIZE-1:0] add_mod(
    input logic [`NTT_REG_SIZE-1:0] a,
    input logic [`NTT_REG_SIZE-1:0] b
);
    longint s;
    s = (longint'(a) + longint'(b)) % longint'(`NTT_Q);
    return s[`NTT_REG_SIZE-1:0];
endfunction

function automatic logic [`NTT_REG_SIZE-1:0] sub_mod(
    input logic [`NTT_REG_SIZE-1:0] a,
    input logic [`NTT_REG_SIZE-1:0] b
);
    longint d;
    // Add q first so the difference never goes negative
    d = (longint'(a) + longint'(`NTT_Q) - longint'(b)) % longint'(`NTT_Q);
    return d[`NTT_REG_SIZE-1:0];
endfunction

function automatic logic [`NTT_REG_SIZE-1:0] mul_mod(
    input logic [`NTT_REG_SIZE-1:0] a,
    input logic [`NTT_REG_SIZE-1:0] b
);
    longint p;
    p = (longint'(a) * longint'(b)) % longint'(`NTT_Q);
    return p[`NTT_REG_SIZE-1:0];
endfunction

// --------------------------------------------------
// Butterfly, network and lane results
// --------------------------------------------------

// ct: u + w*v, u - w*v
// gs: u + v, (u - v)*w
function automatic void butterfly(
    input  ntt_mode_t                m,
    input  logic [`NTT_REG_SIZE-1:0] u,
    input  logic [`NTT_REG_SIZE-1:0] v,
    input  logic [`NTT_REG_SIZE-1:0] w,
    output logic [`NTT_REG_SIZE-1:0] uo,
    output logic [`NTT_REG_SIZE-1:0] vo
);
    if (m == gs) begin
        uo = add_mod(u, v);
        vo = mul_mod(sub_mod(u, v), w);
    end else begin
        uo = add_mod(u, mul_mod(w, v));
        vo = sub_mod(u, mul_mod(w, v));
    end
endfunction

// Result lanes 0..3 hold u20, v20, u21, v21
function automatic logic [3:0][`NTT_REG_SIZE-1:0] expect_network(
    input ntt_mode_t                m,
    input logic [`NTT_REG_SIZE-1:0] u00,
    input logic [`NTT_REG_SIZE-1:0] v00,
    input logic [`NTT_REG_SIZE-1:0] w00,
    input logic [`NTT_REG_SIZE-1:0] u01,
    input logic [`NTT_REG_SIZE-1:0] v01,
    input logic [`NTT_REG_SIZE-1:0] w01,
    input logic [`NTT_REG_SIZE-1:0] w10,
    input logic [`NTT_REG_SIZE-1:0] w11
);
    logic [`NTT_REG_SIZE-1:0]      u10, u11, v10, v11;
    logic [3:0][`NTT_REG_SIZE-1:0] res;
    // Stage one, bf00 feeds u10/u11 and bf01 feeds v10/v11
    butterfly(m, u00, v00, w00, u10, u11);
    butterfly(m, u01, v01, w01, v10, v11);
    // Stage two
    butterfly(m, u10, v10, w10, res[0], res[1]);
    butterfly(m, u11, v11, w11, res[2], res[3]);
    return res;
endfunction

function automatic logic [`NTT_REG_SIZE-1:0] expect_lane(
    input ntt_mode_t                m,
    input logic                     acc,
    input logic [`NTT_REG_SIZE-1:0] u,
    input logic [`NTT_REG_SIZE-1:0] v,
    input logic [`NTT_REG_SIZE-1:0] w
);
    case (m)
        pwm:     return add_mod(mul_mod(u, v), acc ? w : '0);
        pwa:     return add_mod(u, v);
        default: return sub_mod(u, v);
    endcase
endfunction

`endif

// File: bench/tb_ntt_butterfly_2x2.sv
// Testbench for the 2x2 butterfly network: directed and random bursts in every mode
`timescale 1ns/10ps
`default_nettype none
`include "ntt_settings.svh"

module tb_ntt_butterfly_2x2
    import ntt_pkg::*;
();

    // --------------------------------------------------
    // Run length and cycle limit
    // --------------------------------------------------

    localparam int RESET_CYCLES = 4;
    localparam int N_CT         = 100;
    localparam int N_GS         = 100;
    localparam int N_PW         = 25;
    localparam int N_ZERO       = 5;
    localparam int N_FRESH      = 20;
    // Queue drain plus a full enable history flush
    localparam int DRAIN_CYCLES = 4 * `NTT_BF_LATENCY;
    localparam int N_BURSTS     = 7;
    localparam int IDLE_CHECKS  = 20;
    // gs sets take up to three cycles each with their gaps
    localparam int MAX_CYCLES   = 2 * (N_CT + 3 * N_GS + 4 * N_PW + N_ZERO + N_FRESH
                                  + N_BURSTS * DRAIN_CYCLES + RESET_CYCLES + IDLE_CHECKS);

    logic      clk;
    logic      reset_n;
    logic      zeroize;
    ntt_mode_t mode;
    logic      accumulate;
    logic      enable;
    logic [`NTT_REG_SIZE-1:0] u00, v00, w00, u01, v01, w01, w10, w11;
    logic [`NTT_REG_SIZE-1:0] u20, v20, u21, v21;
    logic [3:0][`NTT_REG_SIZE-1:0] pw_u, pw_v, pw_w, pwo;
    logic      ready;

    int cycle_cnt = 0;

    // Expected sets: due cycle, network or lane result, values
    int                            due_q[$];
    bit                            net_q[$];
    logic [3:0][`NTT_REG_SIZE-1:0] exp_q[$];

    `include "ntt_ref.svh"

    ntt_butterfly_2x2 ntt_butterfly_2x2_i (
        .clk          (clk),
        .reset_n      (reset_n),
        .zeroize_i    (zeroize),
        .mode_i       (mode),
        .accumulate_i (accumulate),
        .enable_i     (enable),
        .u00_i        (u00),
        .v00_i        (v00),
        .w00_i        (w00),
        .u01_i        (u01),
        .v01_i        (v01),
        .w01_i        (w01),
        .w10_i        (w10),
        .w11_i        (w11),
        .pw_u_i       (pw_u),
        .pw_v_i       (pw_v),
        .pw_w_i       (pw_w),
        .u20_o        (u20),
        .v20_o        (v20),
        .u21_o        (u21),
        .v21_o        (v21),
        .pwo_o        (pwo),
        .ready_o      (ready)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // --------------------------------------------------
    // Failure reporting and checks
    // --------------------------------------------------

    task automatic report_failure(input string what);
        $display("%s", what);
        $display(">>> FAIL");
        $fatal(1);
    endtask

    task automatic check_value(
        input string                    name,
        input logic [`NTT_REG_SIZE-1:0] got,
        input logic [`NTT_REG_SIZE-1:0] expected
    );
        assert (got === expected)
            else report_failure($sformatf("** Error: %s = 0x%h, expected 0x%h",
                                          name, got, expected));
    endtask

    task automatic check_outputs_zero();
        assert (ready === 1'b0)
            else report_failure("ready_o is high while no set is in flight");
        check_value("u20_o", u20, '0);
        check_value("v20_o", v20, '0);
        check_value("u21_o", u21, '0);
        check_value("v21_o", v21, '0);
        for (int i = 0; i < 4; i++) begin
            check_value($sformatf("pwo_o[%0d]", i), pwo[i], '0);
        end
    endtask

    // Cycle count and run limit
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES) begin
            report_failure("Timeout: the run did not finish within the cycle limit");
        end
    end

    // Outputs are sampled on the falling edge, half a cycle after they settle
    always @(negedge clk) begin
        if (reset_n) begin
            if (ready) begin
                assert (due_q.size() != 0)
                    else report_failure("ready_o pulsed with no set in flight");
                assert (due_q[0] == cycle_cnt)
                    else report_failure("ready_o pulsed in a cycle where no set was due");
                if (net_q[0]) begin
                    check_value("u20_o", u20, exp_q[0][0]);
                    check_value("v20_o", v20, exp_q[0][1]);
                    check_value("u21_o", u21, exp_q[0][2]);
                    check_value("v21_o", v21, exp_q[0][3]);
                end else begin
                    for (int i = 0; i < 4; i++) begin
                        check_value($sformatf("pwo_o[%0d]", i), pwo[i], exp_q[0][i]);
                    end
                end
                void'(due_q.pop_front());
                void'(net_q.pop_front());
                void'(exp_q.pop_front());
            end else if (due_q.size() != 0) begin
                assert (due_q[0] > cycle_cnt)
                    else report_failure("ready_o did not pulse for a set that was due");
            end
        end
    end

    // --------------------------------------------------
    // Stimulus helpers, all driven on the falling edge
    // --------------------------------------------------

    function automatic logic [`NTT_REG_SIZE-1:0] rand_coef();
        return $urandom % `NTT_Q;
    endfunction

    task automatic clear_inputs();
        {u00, v00, w00, u01, v01, w01, w10, w11} = '0;
        pw_u = '0;
        pw_v = '0;
        pw_w = '0;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(negedge clk);
            enable = 1'b0;
        end
    endtask

    task automatic send_network(
        input logic [`NTT_REG_SIZE-1:0] a0, b0, c0, a1, b1, c1, c2, c3
    );
        @(negedge clk);
        {u00, v00, w00, u01, v01, w01, w10, w11} = {a0, b0, c0, a1, b1, c1, c2, c3};
        enable = 1'b1;
        // Two chained butterflies
        due_q.push_back(cycle_cnt + 2 * `NTT_BF_LATENCY);
        net_q.push_back(1'b1);
        exp_q.push_back(expect_network(mode, a0, b0, c0, a1, b1, c1, c2, c3));
    endtask

    task automatic send_random_network();
        send_network(rand_coef(), rand_coef(), rand_coef(), rand_coef(),
                     rand_coef(), rand_coef(), rand_coef(), rand_coef());
    endtask

    task automatic send_lanes();
        logic [3:0][`NTT_REG_SIZE-1:0] res;
        @(negedge clk);
        for (int i = 0; i < 4; i++) begin
            pw_u[i] = rand_coef();
            pw_v[i] = rand_coef();
            pw_w[i] = rand_coef();
            res[i]  = expect_lane(mode, accumulate, pw_u[i], pw_v[i], pw_w[i]);
        end
        enable = 1'b1;
        due_q.push_back(cycle_cnt + ((mode == pwm) ? `NTT_BF_LATENCY : `NTT_PWAS_LATENCY));
        net_q.push_back(1'b0);
        exp_q.push_back(res);
    endtask

    // Wait out the burst, then let the enable history empty before a mode change
    task automatic drain();
        while (due_q.size() != 0) begin
            @(negedge clk);
            enable = 1'b0;
        end
        idle_cycles(2 * `NTT_BF_LATENCY);
    endtask

    task automatic lane_burst(input ntt_mode_t m, input logic acc);
        mode       = m;
        accumulate = acc;
        repeat (N_PW) send_lanes();
        drain();
    endtask

    // --------------------------------------------------
    // Test sequence
    // --------------------------------------------------

    initial begin : stimulus
        logic [`NTT_REG_SIZE-1:0] qm1;
        qm1 = `NTT_Q - 1;
        void'($urandom(32'hebb0));
        clear_inputs();
        mode       = ct;
        accumulate = 1'b0;
        enable     = 1'b0;
        zeroize    = 1'b0;
        reset_n    = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset_n = 1'b1;

        // Quiet outputs after reset
        repeat (3) begin
            @(negedge clk);
            check_outputs_zero();
        end

        // ct burst, edge cases first, all back to back
        send_network('0, '0, '0, '0, '0, '0, '0, '0);
        send_network(qm1, qm1, qm1, qm1, qm1, qm1, qm1, qm1);
        send_network(qm1, qm1, 23'd1, '0, qm1, 23'd1, 23'd1, 23'd1);
        send_network('0, qm1, qm1, qm1, '0, 23'd1, qm1, '0);
        repeat (N_CT - 4) send_random_network();
        drain();

        // gs burst with random gaps
        mode = gs;
        repeat (N_GS) begin
            send_random_network();
            idle_cycles($urandom_range(0, 2));
        end
        drain();

        // Pointwise lanes
        lane_burst(pwm, 1'b0);
        lane_burst(pwm, 1'b1);
        lane_burst(pwa, 1'b0);
        lane_burst(pws, 1'b0);

        // Zeroize with ct sets still in flight
        mode = ct;
        repeat (N_ZERO) send_random_network();
        @(negedge clk);
        enable  = 1'b0;
        zeroize = 1'b1;
        clear_inputs();
        due_q.delete();
        net_q.delete();
        exp_q.delete();
        idle_cycles(2);
        zeroize = 1'b0;
        repeat (10) begin
            @(negedge clk);
            check_outputs_zero();
        end

        // Fresh burst after the clear
        repeat (N_FRESH) send_random_network();
        drain();

        if (due_q.size() == 0) begin
            $display(">>> PASS");
            $finish;
        end else begin
            report_failure("Expected results were left over at the end of the run");
        end
    end

endmodule

`default_nettype wire

// File: src/ntt_butterfly_2x2.sv
// 2x2 butterfly network: two chained ct/gs stages or four independent pointwise lanes
`timescale 1ns/10ps
`default_nettype none
`include "ntt_settings.svh"

module ntt_butterfly_2x2
    import ntt_pkg::*;
(
    input  wire                                clk,
    input  wire                                reset_n,
    input  wire                                zeroize_i,
    input  wire ntt_mode_t                     mode_i,
    input  wire                                accumulate_i,
    input  wire                                enable_i,
    input  wire [`NTT_REG_SIZE-1:0]            u00_i,
    input  wire [`NTT_REG_SIZE-1:0]            v00_i,
    input  wire [`NTT_REG_SIZE-1:0]            w00_i,
    input  wire [`NTT_REG_SIZE-1:0]            u01_i,
    input  wire [`NTT_REG_SIZE-1:0]            v01_i,
    input  wire [`NTT_REG_SIZE-1:0]            w01_i,
    input  wire [`NTT_REG_SIZE-1:0]            w10_i,
    input  wire [`NTT_REG_SIZE-1:0]            w11_i,
    input  wire [3:0][`NTT_REG_SIZE-1:0]       pw_u_i,
    input  wire [3:0][`NTT_REG_SIZE-1:0]       pw_v_i,
    input  wire [3:0][`NTT_REG_SIZE-1:0]       pw_w_i,
    output logic [`NTT_REG_SIZE-1:0]           u20_o,
    output logic [`NTT_REG_SIZE-1:0]           v20_o,
    output logic [`NTT_REG_SIZE-1:0]           u21_o,
    output logic [`NTT_REG_SIZE-1:0]           v21_o,
    output logic [3:0][`NTT_REG_SIZE-1:0]      pwo_o,
    output logic                               ready_o
);

    logic pwo_mode;

    // Butterfly operands, index 0..3 = bf00, bf01, bf10, bf11
    logic [3:0][`NTT_REG_SIZE-1:0] bf_u;
    logic [3:0][`NTT_REG_SIZE-1:0] bf_v;
    logic [3:0][`NTT_REG_SIZE-1:0] bf_w;

    // Stage one results feeding stage two
    logic [`NTT_REG_SIZE-1:0] u10;
    logic [`NTT_REG_SIZE-1:0] u11;
    logic [`NTT_REG_SIZE-1:0] v10;
    logic [`NTT_REG_SIZE-1:0] v11;

    // Stage two twiddles, aligned with stage one output
    logic [`NTT_BF_LATENCY-1:0][`NTT_REG_SIZE-1:0] w10_dly;
    logic [`NTT_BF_LATENCY-1:0][`NTT_REG_SIZE-1:0] w11_dly;

    // Enable history, deep enough for two chained butterflies
    logic [2*`NTT_BF_LATENCY-1:0] en_sr;

    assign pwo_mode = (mode_i inside {pwm, pwa, pws});

    // --------------------------------------------------
    // Input select
    // --------------------------------------------------

    always_comb begin
        if (pwo_mode) begin
            // Four independent lanes, no chaining and no twiddle delay
            bf_u = pw_u_i;
            bf_v = pw_v_i;
            bf_w = pw_w_i;
        end else begin
            bf_u[0] = u00_i;
            bf_v[0] = v00_i;
            bf_w[0] = w00_i;
            bf_u[1] = u01_i;
            bf_v[1] = v01_i;
            bf_w[1] = w01_i;
            // Stage two takes stage one output, crossed over
            bf_u[2] = u10;
            bf_v[2] = v10;
            bf_w[2] = w10_dly[`NTT_BF_LATENCY-1];
            bf_u[3] = u11;
            bf_v[3] = v11;
            bf_w[3] = w11_dly[`NTT_BF_LATENCY-1];
        end
    end

    // --------------------------------------------------
    // Stage one
    // --------------------------------------------------

    ntt_butterfly bf00 (
        .clk          (clk),
        .reset_n      (reset_n),
        .zeroize_i    (zeroize_i),
        .mode_i       (mode_i),
        .accumulate_i (accumulate_i),
        .u_i          (bf_u[0]),
        .v_i          (bf_v[0]),
        .w_i          (bf_w[0]),
        .u_o          (u10),
        .v_o          (u11),
        .pw_res_o     (pwo_o[0])
    );

    ntt_butterfly bf01 (
        .clk          (clk),
        .reset_n      (reset_n),
        .zeroize_i    (zeroize_i),
        .mode_i       (mode_i),
        .accumulate_i (accumulate_i),
        .u_i          (bf_u[1]),
        .v_i          (bf_v[1]),
        .w_i          (bf_w[1]),
        .u_o          (v10),
        .v_o          (v11),
        .pw_res_o     (pwo_o[1])
    );

    // --------------------------------------------------
    // Stage two
    // --------------------------------------------------

    ntt_butterfly bf10 (
        .clk          (clk),
        .reset_n      (reset_n),
        .zeroize_i    (zeroize_i),
        .mode_i       (mode_i),
        .accumulate_i (accumulate_i),
        .u_i          (bf_u[2]),
        .v_i          (bf_v[2]),
        .w_i          (bf_w[2]),
        .u_o          (u20_o),
        .v_o          (v20_o),
        .pw_res_o     (pwo_o[2])
    );

    ntt_butterfly bf11 (
        .clk          (clk),
        .reset_n      (reset_n),
        .zeroize_i    (zeroize_i),
        .mode_i       (mode_i),
        .accumulate_i (accumulate_i),
        .u_i          (bf_u[3]),
        .v_i          (bf_v[3]),
        .w_i          (bf_w[3]),
        .u_o          (u21_o),
        .v_o          (v21_o),
        .pw_res_o     (pwo_o[3])
    );

    // --------------------------------------------------
    // Twiddle delay and ready timing
    // --------------------------------------------------

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            w10_dly <= '0;
            w11_dly <= '0;
            en_sr   <= '0;
        end else if (zeroize_i) begin
            // Sets in flight are dropped, no ready follows
            w10_dly <= '0;
            w11_dly <= '0;
            en_sr   <= '0;
        end else begin
            w10_dly <= {w10_dly[`NTT_BF_LATENCY-2:0], w10_i};
            w11_dly <= {w11_dly[`NTT_BF_LATENCY-2:0], w11_i};
            en_sr   <= {en_sr[2*`NTT_BF_LATENCY-2:0], enable_i};
        end
    end

    // Tap depth by mode, mode is held steady while sets are in flight
    always_comb begin
        case (mode_i)
            ct, gs:   ready_o = en_sr[2*`NTT_BF_LATENCY-1];
            pwm:      ready_o = en_sr[`NTT_BF_LATENCY-1];
            pwa, pws: ready_o = en_sr[`NTT_PWAS_LATENCY-1];
            default:  ready_o = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

// File: src/ntt_butterfly.sv
// Butterfly unit: ct and gs butterflies plus pointwise multiply, add and subtract mod q
`timescale 1ns/10ps
`default_nettype none
`include "ntt_settings.svh"

module ntt_butterfly
    import ntt_pkg::*;
(
    input  wire                      clk,
    input  wire                      reset_n,
    input  wire                      zeroize_i,
    input  wire ntt_mode_t           mode_i,
    input  wire                      accumulate_i,
    input  wire [`NTT_REG_SIZE-1:0]  u_i,
    input  wire [`NTT_REG_SIZE-1:0]  v_i,
    input  wire [`NTT_REG_SIZE-1:0]  w_i,
    output logic [`NTT_REG_SIZE-1:0] u_o,
    output logic [`NTT_REG_SIZE-1:0] v_o,
    output logic [`NTT_REG_SIZE-1:0] pw_res_o
);

    // --------------------------------------------------
    // Modular add and subtract, operands below q
    // --------------------------------------------------

    function automatic logic [`NTT_REG_SIZE-1:0] mod_add(
        input logic [`NTT_REG_SIZE-1:0] a,
        input logic [`NTT_REG_SIZE-1:0] b
    );
        logic [`NTT_REG_SIZE:0] s;
        s = {1'b0, a} + {1'b0, b};
        if (s >= {1'b0, `NTT_Q}) begin
            s = s - {1'b0, `NTT_Q};
        end
        return s[`NTT_REG_SIZE-1:0];
    endfunction

    function automatic logic [`NTT_REG_SIZE-1:0] mod_sub(
        input logic [`NTT_REG_SIZE-1:0] a,
        input logic [`NTT_REG_SIZE-1:0] b
    );
        logic [`NTT_REG_SIZE:0] d;
        d = {1'b0, a} - {1'b0, b};
        // Wrapped difference, fold back by adding q
        if (a < b) begin
            d = d + {1'b0, `NTT_Q};
        end
        return d[`NTT_REG_SIZE-1:0];
    endfunction

    // Front add/sub on the raw inputs
    logic [`NTT_REG_SIZE-1:0] add_in;
    logic [`NTT_REG_SIZE-1:0] sub_in;

    // Front stage: gs difference or pwa/pws result, twiddle aligned to it
    logic [`NTT_REG_SIZE-1:0] s1_r;
    logic [`NTT_REG_SIZE-1:0] w_r;

    // Delay line running alongside the multiplier
    logic [`NTT_REG_SIZE-1:0]                        dly_in;
    logic [`NTT_MULT_LATENCY-1:0][`NTT_REG_SIZE-1:0] dly_r;

    // Multiplier operands and product
    logic [`NTT_REG_SIZE-1:0] mult_a;
    logic [`NTT_REG_SIZE-1:0] mult_b;
    logic [`NTT_REG_SIZE-1:0] prod;

    // Back stage results
    logic [`NTT_REG_SIZE-1:0] u_r;
    logic [`NTT_REG_SIZE-1:0] v_r;

    assign add_in = mod_add(u_i, v_i);
    assign sub_in = mod_sub(u_i, v_i);

    // --------------------------------------------------
    // Operand routing per mode
    // --------------------------------------------------

    always_comb begin
        case (mode_i)
            ct: begin
                // w*v now, u waits in the delay line
                mult_a = w_i;
                mult_b = v_i;
                dly_in = u_i;
            end
            gs: begin
                // Difference is registered first, so w is taken one cycle late
                // Sum enters the delay line directly, ready at the back stage
                mult_a = s1_r;
                mult_b = w_r;
                dly_in = add_in;
            end
            pwm: begin
                // Addend rides the delay line, zero without accumulate
                mult_a = u_i;
                mult_b = v_i;
                dly_in = accumulate_i ? w_i : '0;
            end
            default: begin
                mult_a = '0;
                mult_b = '0;
                dly_in = '0;
            end
        endcase
    end

    ntt_mod_mult mult_i (
        .clk       (clk),
        .reset_n   (reset_n),
        .zeroize_i (zeroize_i),
        .a_i       (mult_a),
        .b_i       (mult_b),
        .p_o       (prod)
    );

    // --------------------------------------------------
    // Front stage and delay line
    // --------------------------------------------------

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            s1_r  <= '0;
            w_r   <= '0;
            dly_r <= '0;
        end else if (zeroize_i) begin
            s1_r  <= '0;
            w_r   <= '0;
            dly_r <= '0;
        end else begin
            // pwa keeps the sum, gs and pws keep the difference
            s1_r  <= (mode_i == pwa) ? add_in : sub_in;
            w_r   <= w_i;
            dly_r <= {dly_r[`NTT_MULT_LATENCY-2:0], dly_in};
        end
    end

    // --------------------------------------------------
    // Back stage, lands 4 cycles after the inputs
    // --------------------------------------------------

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            u_r <= '0;
            v_r <= '0;
        end else if (zeroize_i) begin
            u_r <= '0;
            v_r <= '0;
        end else begin
            // ct: u + w*v, pwm: u*v + w, gs: delayed sum
            u_r <= (mode_i == gs) ? dly_r[`NTT_MULT_LATENCY-1]
                                  : mod_add(dly_r[`NTT_MULT_LATENCY-1], prod);
            // ct only: u - w*v
            v_r <= mod_sub(dly_r[`NTT_MULT_LATENCY-1], prod);
        end
    end

    assign u_o = u_r;

    // In gs the product itself arrives in the back-stage cycle
    assign v_o = (mode_i == gs) ? prod : v_r;

    // pwa/pws come from the front stage, pwm from the back stage
    assign pw_res_o = (mode_i inside {pwa, pws}) ? s1_r : u_r;

endmodule

`default_nettype wire

// File: src/ntt_mod_mult.sv
// Modular multiplier: a*b mod q by Barrett reduction in three pipeline stages
`timescale 1ns/10ps
`default_nettype none
`include "ntt_settings.svh"

module ntt_mod_mult (
    input  wire                      clk,
    input  wire                      reset_n,
    input  wire                      zeroize_i,
    input  wire [`NTT_REG_SIZE-1:0]  a_i,
    input  wire [`NTT_REG_SIZE-1:0]  b_i,
    output logic [`NTT_REG_SIZE-1:0] p_o
);

    // Stage 1: full 46-bit product
    logic [2*`NTT_REG_SIZE-1:0] prod_r;

    // Stage 2: quotient estimate plus product carried along
    logic [3*`NTT_REG_SIZE:0]   est_full;
    logic [`NTT_REG_SIZE:0]     qhat_r;
    logic [2*`NTT_REG_SIZE-1:0] prod_d_r;

    // Stage 3 datapath
    logic [2*`NTT_REG_SIZE:0]   qq_full;
    logic [`NTT_REG_SIZE+1:0]   rem_raw;
    logic [`NTT_REG_SIZE+1:0]   rem_red;

    // --------------------------------------------------
    // Barrett quotient estimate
    // --------------------------------------------------

    // Full precision a*mu, keep bits above 2^46
    // Estimate is at most one below floor(a/q) since a < q^2 < 2^46
    assign est_full = prod_r * `NTT_BARRETT_MU;

    // --------------------------------------------------
    // Remainder and final correction
    // --------------------------------------------------

    assign qq_full = qhat_r * `NTT_Q;

    // Remainder is below 2q < 2^24, so 25 low bits are enough
    assign rem_raw = prod_d_r[`NTT_REG_SIZE+1:0] - qq_full[`NTT_REG_SIZE+1:0];

    // One conditional subtract brings it below q
    always_comb begin
        if (rem_raw >= {2'b00, `NTT_Q}) begin
            rem_red = rem_raw - {2'b00, `NTT_Q};
        end else begin
            rem_red = rem_raw;
        end
    end

    // --------------------------------------------------
    // Pipeline registers
    // --------------------------------------------------

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            prod_r   <= '0;
            qhat_r   <= '0;
            prod_d_r <= '0;
            p_o      <= '0;
        end else if (zeroize_i) begin
            prod_r   <= '0;
            qhat_r   <= '0;
            prod_d_r <= '0;
            p_o      <= '0;
        end else begin
            // Stage 1
            prod_r   <= a_i * b_i;
            // Stage 2
            qhat_r   <= est_full[3*`NTT_REG_SIZE:2*`NTT_REG_SIZE];
            prod_d_r <= prod_r;
            // Stage 3, result below q
            p_o      <= rem_red[`NTT_REG_SIZE-1:0];
        end
    end

endmodule

`default_nettype wire

// File: src/ntt_pkg.sv
// NTT package: butterfly operating mode shared by the datapath and the bench
`default_nettype none

package ntt_pkg;

    // Butterfly mode
    // ct  : forward butterfly, u + w*v and u - w*v
    // gs  : inverse butterfly, u + v and (u - v)*w
    // pwm : pointwise multiply, optional accumulate
    // pwa : pointwise add
    // pws : pointwise subtract
    typedef enum logic [2:0] {
        ct  = 3'd0,
        gs  = 3'd1,
        pwm = 3'd2,
        pwa = 3'd3,
        pws = 3'd4
    } ntt_mode_t;

endpackage

`default_nettype wire

// File: src/ntt_settings.svh
// NTT settings: modulus, coefficient width, Barrett constant and pipeline latencies
`ifndef NTT_SETTINGS_SVH
`define NTT_SETTINGS_SVH

// --------------------------------------------------
// Modulus arithmetic
// --------------------------------------------------

// Prime modulus q = 2^23 - 2^13 + 1
`define NTT_Q 23'd8380417

// Coefficient width, every value is kept below q
`define NTT_REG_SIZE 23

// Barrett constant floor(2^46 / q), 24 bits wide
`define NTT_BARRETT_MU 24'd8396807

// --------------------------------------------------
// Pipeline latencies in clock cycles
// --------------------------------------------------

// Product, quotient estimate, reduced remainder
`define NTT_MULT_LATENCY 3

// One ct, gs or pwm butterfly
// Multiplier plus one add/sub stage
`define NTT_BF_LATENCY 4

// Pointwise add or subtract, a single registered add/sub
`define NTT_PWAS_LATENCY 1

`endif
